// File: hdl/issue_defs.svh
// ------------------------------
// Global sizes of the issue stage
//   data path width
//   register file size
//   scoreboard depth and index width
// ------------------------------
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Operand and result width in bits
`define ISSUE_XLEN 16

// General purpose registers, register zero included
`define ISSUE_NR_REGS 8

// In-flight instructions held by the scoreboard
`define ISSUE_NR_SB_ENTRIES 4

// Bits needed to index one scoreboard entry
`define ISSUE_TRANS_ID_BITS 2

`endif

// File: hdl/issue_pkg.sv
// ------------------------------
// Issue stage package
//   data, register and transaction id types
//   functional unit select enum
//   operand read FSM states
// ------------------------------
`default_nettype none

`include "issue_defs.svh"

package issue_pkg;

  // Operand or result value
  typedef logic [`ISSUE_XLEN-1:0] xlen_t;

  // Architectural register number
  typedef logic [$clog2(`ISSUE_NR_REGS)-1:0] reg_addr_t;

  // Scoreboard slot, travels through the units and back on writeback
  typedef logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id_t;

  // Operation code, opaque here and passed on to the unit
  typedef logic [3:0] op_t;

  // Target functional unit
  typedef enum logic [1:0] {
    FU_ALU  = 2'd0,
    FU_LSU  = 2'd1,
    FU_MULT = 2'd2
  } fu_t;

  // Operand read control
  typedef enum logic [1:0] {
    IRO_IDLE     = 2'd0,
    IRO_STALL    = 2'd1,
    IRO_WAIT_FU  = 2'd2
  } iro_state_t;

endpackage

`default_nettype wire

// File: hdl/scoreboard.sv
// ------------------------------
// Scoreboard
//   four entry ring of in-flight instructions
//   decode accept, issue offer, writeback capture
//   per entry forwarding view and commit offer
// ------------------------------
`default_nettype none

`include "issue_defs.svh"

module scoreboard
  import issue_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      flush_i,
  // Decode side
  input  wire logic      decoded_valid_i,
  input  wire fu_t       decoded_fu_i,
  input  wire op_t       decoded_op_i,
  input  wire reg_addr_t decoded_rd_i,
  input  wire reg_addr_t decoded_rs1_i,
  input  wire reg_addr_t decoded_rs2_i,
  output logic           decoded_ack_o,
  output logic           sb_full_o,
  // Oldest unissued entry towards operand read
  output logic           issue_valid_o,
  output fu_t            issue_fu_o,
  output op_t            issue_op_o,
  output reg_addr_t      issue_rd_o,
  output reg_addr_t      issue_rs1_o,
  output reg_addr_t      issue_rs2_o,
  output trans_id_t      issue_id_o,
  input  wire logic      issue_ack_i,
  // Writeback from the functional units
  input  wire logic      wb_valid_i,
  input  wire trans_id_t wb_id_i,
  input  wire xlen_t     wb_data_i,
  // Forwarding view, one slot per entry
  output logic [`ISSUE_NR_SB_ENTRIES-1:0] fwd_busy_o,
  output logic [`ISSUE_NR_SB_ENTRIES-1:0] fwd_done_o,
  output reg_addr_t      fwd_rd_o [`ISSUE_NR_SB_ENTRIES],
  output xlen_t          fwd_result_o [`ISSUE_NR_SB_ENTRIES],
  // Commit side
  output logic           commit_valid_o,
  output reg_addr_t      commit_rd_o,
  output xlen_t          commit_result_o,
  input  wire logic      commit_ack_i
);

  // Entry status bits
  logic [`ISSUE_NR_SB_ENTRIES-1:0] valid_q, issued_q, done_q;

  // Entry payload, no reset needed
  fu_t       fu_q     [`ISSUE_NR_SB_ENTRIES];
  op_t       op_q     [`ISSUE_NR_SB_ENTRIES];
  reg_addr_t rd_q     [`ISSUE_NR_SB_ENTRIES];
  reg_addr_t rs1_q    [`ISSUE_NR_SB_ENTRIES];
  reg_addr_t rs2_q    [`ISSUE_NR_SB_ENTRIES];
  xlen_t     result_q [`ISSUE_NR_SB_ENTRIES];

  // Ring pointers and occupancy
  trans_id_t commit_ptr_q, issue_ptr_q, write_ptr_q;
  logic [`ISSUE_TRANS_ID_BITS:0] count_q;

  logic accept, issue_fire, commit_fire, wb_fire;

  assign sb_full_o     = (count_q == `ISSUE_NR_SB_ENTRIES);
  assign decoded_ack_o = ~sb_full_o;
  assign accept        = decoded_valid_i & decoded_ack_o;

  // Oldest entry not yet handed to operand read
  assign issue_valid_o = valid_q[issue_ptr_q] & ~issued_q[issue_ptr_q];
  assign issue_fu_o    = fu_q[issue_ptr_q];
  assign issue_op_o    = op_q[issue_ptr_q];
  assign issue_rd_o    = rd_q[issue_ptr_q];
  assign issue_rs1_o   = rs1_q[issue_ptr_q];
  assign issue_rs2_o   = rs2_q[issue_ptr_q];
  assign issue_id_o    = issue_ptr_q;
  assign issue_fire    = issue_valid_o & issue_ack_i;

  // Stale ids after a flush are ignored
  assign wb_fire = wb_valid_i & valid_q[wb_id_i];

  // Commit offer for the head entry once it has a result
  assign commit_valid_o  = valid_q[commit_ptr_q] & done_q[commit_ptr_q];
  assign commit_rd_o     = rd_q[commit_ptr_q];
  assign commit_result_o = result_q[commit_ptr_q];
  assign commit_fire     = commit_valid_o & commit_ack_i;

  // Busy means issued without result yet
  always_comb begin
    for (int i = 0; i < `ISSUE_NR_SB_ENTRIES; i++) begin
      fwd_busy_o[i]   = valid_q[i] & issued_q[i] & ~done_q[i];
      fwd_done_o[i]   = valid_q[i] & done_q[i];
      fwd_rd_o[i]     = rd_q[i];
      fwd_result_o[i] = result_q[i];
    end
  end

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q      <= '0;
      issued_q     <= '0;
      done_q       <= '0;
      commit_ptr_q <= '0;
      issue_ptr_q  <= '0;
      write_ptr_q  <= '0;
      count_q      <= '0;
    end else if (flush_i) begin
      // Drop everything in flight
      valid_q      <= '0;
      issued_q     <= '0;
      done_q       <= '0;
      commit_ptr_q <= '0;
      issue_ptr_q  <= '0;
      write_ptr_q  <= '0;
      count_q      <= '0;
    end else begin
      if (accept) begin
        valid_q[write_ptr_q]  <= 1'b1;
        issued_q[write_ptr_q] <= 1'b0;
        done_q[write_ptr_q]   <= 1'b0;
        write_ptr_q           <= write_ptr_q + 1'b1;
      end
      if (issue_fire) begin
        issued_q[issue_ptr_q] <= 1'b1;
        issue_ptr_q           <= issue_ptr_q + 1'b1;
      end
      if (wb_fire) begin
        done_q[wb_id_i] <= 1'b1;
      end
      // Head slot is freed, never the one being written
      if (commit_fire) begin
        valid_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q          <= commit_ptr_q + 1'b1;
      end
      count_q <= count_q + {{`ISSUE_TRANS_ID_BITS{1'b0}}, accept}
                         - {{`ISSUE_TRANS_ID_BITS{1'b0}}, commit_fire};
    end
  end

  // Payload capture on accept and writeback
  always_ff @(posedge clk_i) begin
    if (accept) begin
      fu_q[write_ptr_q]  <= decoded_fu_i;
      op_q[write_ptr_q]  <= decoded_op_i;
      rd_q[write_ptr_q]  <= decoded_rd_i;
      rs1_q[write_ptr_q] <= decoded_rs1_i;
      rs2_q[write_ptr_q] <= decoded_rs2_i;
    end
    if (wb_fire) begin
      result_q[wb_id_i] <= wb_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/issue_read_operands.sv
// ------------------------------
// Operand read and dispatch
//   RAW hazard check against older entries
//   forwarding or register file operand select
//   registered unit valids held under back-pressure
// ------------------------------
`default_nettype none

`include "issue_defs.svh"

module issue_read_operands
  import issue_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      flush_i,
  // Offered instruction
  input  wire logic      issue_valid_i,
  input  wire fu_t       issue_fu_i,
  input  wire op_t       issue_op_i,
  input  wire reg_addr_t issue_rs1_i,
  input  wire reg_addr_t issue_rs2_i,
  input  wire trans_id_t issue_id_i,
  output logic           issue_ack_o,
  // Forwarding view from the scoreboard
  input  wire logic [`ISSUE_NR_SB_ENTRIES-1:0] fwd_busy_i,
  input  wire logic [`ISSUE_NR_SB_ENTRIES-1:0] fwd_done_i,
  input  wire reg_addr_t fwd_rd_i [`ISSUE_NR_SB_ENTRIES],
  input  wire xlen_t     fwd_result_i [`ISSUE_NR_SB_ENTRIES],
  // Register file read ports
  output reg_addr_t      raddr_a_o,
  output reg_addr_t      raddr_b_o,
  input  wire xlen_t     rdata_a_i,
  input  wire xlen_t     rdata_b_i,
  // Functional unit dispatch
  input  wire logic      alu_ready_i,
  input  wire logic      lsu_ready_i,
  input  wire logic      mult_ready_i,
  output logic           alu_valid_o,
  output logic           lsu_valid_o,
  output logic           mult_valid_o,
  output op_t            fu_op_o,
  output trans_id_t      fu_trans_id_o,
  output xlen_t          operand_a_o,
  output xlen_t          operand_b_o,
  output logic           stall_issue_o
);

  iro_state_t state_q, state_d;
  logic  stall_a, stall_b, hazard, out_free, dispatch;
  xlen_t opnd_a, opnd_b;

  // Source n resolves to the youngest issued entry writing it
  // Issue is in order so every issued entry is older than the offer
  function automatic void resolve_src(input reg_addr_t rs, input xlen_t rf_val,
                                      output logic stall, output xlen_t val);
    trans_id_t idx;
    logic      found;
    stall = 1'b0;
    val   = rf_val;
    found = 1'b0;
    if (rs != '0) begin
      // Walk back from the entry just before the offer
      for (int k = 1; k < `ISSUE_NR_SB_ENTRIES; k++) begin
        idx = issue_id_i - trans_id_t'(k);
        if (!found && (fwd_busy_i[idx] || fwd_done_i[idx]) && fwd_rd_i[idx] == rs) begin
          found = 1'b1;
          stall = fwd_busy_i[idx];
          val   = fwd_result_i[idx];
        end
      end
    end
  endfunction

  assign raddr_a_o = issue_rs1_i;
  assign raddr_b_o = issue_rs2_i;

  always_comb begin
    resolve_src(issue_rs1_i, rdata_a_i, stall_a, opnd_a);
    resolve_src(issue_rs2_i, rdata_b_i, stall_b, opnd_b);
  end

  assign hazard        = stall_a | stall_b;
  assign stall_issue_o = issue_valid_i & hazard;

  // Dispatch slot is free unless a held valid is still waiting for ready
  assign out_free = (state_q != IRO_WAIT_FU) |
                    (alu_valid_o & alu_ready_i) |
                    (lsu_valid_o & lsu_ready_i) |
                    (mult_valid_o & mult_ready_i);

  assign dispatch    = issue_valid_i & ~hazard & out_free & ~flush_i;
  assign issue_ack_o = dispatch;

  // ------------------------------
  // FSM next state
  // ------------------------------
  always_comb begin
    state_d = IRO_IDLE;
    if (flush_i) begin
      state_d = IRO_IDLE;
    end else if (dispatch || !out_free) begin
      state_d = IRO_WAIT_FU;
    end else if (issue_valid_i && hazard) begin
      state_d = IRO_STALL;
    end
  end

  // Unit valids, pulse when ready, held otherwise
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= IRO_IDLE;
      alu_valid_o  <= 1'b0;
      lsu_valid_o  <= 1'b0;
      mult_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (flush_i || out_free) begin
        alu_valid_o  <= dispatch && (issue_fu_i == FU_ALU);
        lsu_valid_o  <= dispatch && (issue_fu_i == FU_LSU);
        mult_valid_o <= dispatch && (issue_fu_i == FU_MULT);
      end
    end
  end

  // Dispatch payload, stable while held
  always_ff @(posedge clk_i) begin
    if (dispatch) begin
      fu_op_o       <= issue_op_i;
      fu_trans_id_o <= issue_id_i;
      operand_a_o   <= opnd_a;
      operand_b_o   <= opnd_b;
    end
  end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
// ------------------------------
// General purpose registers
//   two combinational reads, one write
//   register zero reads zero
// ------------------------------
`default_nettype none

`include "issue_defs.svh"

module register_file
  import issue_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire reg_addr_t raddr_a_i,
  input  wire reg_addr_t raddr_b_i,
  output xlen_t          rdata_a_o,
  output xlen_t          rdata_b_o,
  input  wire logic      we_i,
  input  wire reg_addr_t waddr_i,
  input  wire xlen_t     wdata_i
);

  xlen_t regs_q [`ISSUE_NR_REGS];

  // Write port, register zero never written so it stays cleared
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // No write-through, the written value shows after the edge
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: hdl/issue_stage.sv
// ------------------------------
// Issue stage top
//   scoreboard, operand read, register file
// ------------------------------
`default_nettype none

`include "issue_defs.svh"

module issue_stage
  import issue_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      flush_i,
  // Decode
  input  wire logic      decoded_valid_i,
  input  wire fu_t       decoded_fu_i,
  input  wire op_t       decoded_op_i,
  input  wire reg_addr_t decoded_rd_i,
  input  wire reg_addr_t decoded_rs1_i,
  input  wire reg_addr_t decoded_rs2_i,
  output logic           decoded_ack_o,
  output logic           sb_full_o,
  // Functional units
  input  wire logic      alu_ready_i,
  input  wire logic      lsu_ready_i,
  input  wire logic      mult_ready_i,
  output logic           alu_valid_o,
  output logic           lsu_valid_o,
  output logic           mult_valid_o,
  output op_t            fu_op_o,
  output trans_id_t      fu_trans_id_o,
  output xlen_t          operand_a_o,
  output xlen_t          operand_b_o,
  output logic           stall_issue_o,
  // Writeback
  input  wire logic      wb_valid_i,
  input  wire trans_id_t wb_id_i,
  input  wire xlen_t     wb_data_i,
  // Commit and register file write
  output logic           commit_valid_o,
  output reg_addr_t      commit_rd_o,
  output xlen_t          commit_result_o,
  input  wire logic      commit_ack_i,
  input  wire logic      we_i,
  input  wire reg_addr_t waddr_i,
  input  wire xlen_t     wdata_i
);

  // ------------------------------
  // Scoreboard to operand read
  // ------------------------------
  logic      issue_valid, issue_ack;
  fu_t       issue_fu;
  op_t       issue_op;
  reg_addr_t issue_rs1, issue_rs2;
  trans_id_t issue_id;

  logic [`ISSUE_NR_SB_ENTRIES-1:0] fwd_busy, fwd_done;
  reg_addr_t fwd_rd [`ISSUE_NR_SB_ENTRIES];
  xlen_t     fwd_result [`ISSUE_NR_SB_ENTRIES];

  // Register file read ports
  reg_addr_t raddr_a, raddr_b;
  xlen_t     rdata_a, rdata_b;

  scoreboard i_scoreboard (
    .clk_i, .rst_n_i, .flush_i,
    .decoded_valid_i, .decoded_fu_i, .decoded_op_i,
    .decoded_rd_i, .decoded_rs1_i, .decoded_rs2_i,
    .decoded_ack_o, .sb_full_o,
    .issue_valid_o  (issue_valid),
    .issue_fu_o     (issue_fu),
    .issue_op_o     (issue_op),
    // Destination stays inside the scoreboard for forwarding and commit
    .issue_rd_o     (),
    .issue_rs1_o    (issue_rs1),
    .issue_rs2_o    (issue_rs2),
    .issue_id_o     (issue_id),
    .issue_ack_i    (issue_ack),
    .wb_valid_i, .wb_id_i, .wb_data_i,
    .fwd_busy_o     (fwd_busy),
    .fwd_done_o     (fwd_done),
    .fwd_rd_o       (fwd_rd),
    .fwd_result_o   (fwd_result),
    .commit_valid_o, .commit_rd_o, .commit_result_o, .commit_ack_i
  );

  issue_read_operands i_issue_read_operands (
    .clk_i, .rst_n_i, .flush_i,
    .issue_valid_i  (issue_valid),
    .issue_fu_i     (issue_fu),
    .issue_op_i     (issue_op),
    .issue_rs1_i    (issue_rs1),
    .issue_rs2_i    (issue_rs2),
    .issue_id_i     (issue_id),
    .issue_ack_o    (issue_ack),
    .fwd_busy_i     (fwd_busy),
    .fwd_done_i     (fwd_done),
    .fwd_rd_i       (fwd_rd),
    .fwd_result_i   (fwd_result),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .alu_ready_i, .lsu_ready_i, .mult_ready_i,
    .alu_valid_o, .lsu_valid_o, .mult_valid_o,
    .fu_op_o, .fu_trans_id_o, .operand_a_o, .operand_b_o,
    .stall_issue_o
  );

  // Written by the external commit stage
  register_file i_register_file (
    .clk_i, .rst_n_i,
    .raddr_a_i      (raddr_a),
    .raddr_b_i      (raddr_b),
    .rdata_a_o      (rdata_a),
    .rdata_b_o      (rdata_b),
    .we_i, .waddr_i, .wdata_i
  );

endmodule

`default_nettype wire

// File: tests/tb_issue_stage.sv
// ------------------------------
// Issue stage testbench
//   stimulus table applied in a loop
//   functional unit model with LCG writeback delay
//   commit model writing the register file
// ------------------------------
`default_nettype none

module tb_issue_stage
  import issue_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 60;

  // Table entry modes
  localparam logic [2:0] M_PLAIN = 3'd0;
  localparam logic [2:0] M_HOLD  = 3'd1;
  localparam logic [2:0] M_FWD   = 3'd2;
  localparam logic [2:0] M_RAWP  = 3'd3;
  localparam logic [2:0] M_RAW   = 3'd4;
  localparam logic [2:0] M_BP    = 3'd5;
  localparam logic [2:0] M_FLUSH = 3'd6;

  typedef struct packed {
    fu_t        fu;
    op_t        op;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      result;
    xlen_t      exp_a;
    xlen_t      exp_b;
    logic [2:0] mode;
  } vec_t;

  logic      clk_i, rst_n_i, flush_i;
  logic      decoded_valid_i, decoded_ack_o, sb_full_o;
  fu_t       decoded_fu_i;
  op_t       decoded_op_i;
  reg_addr_t decoded_rd_i, decoded_rs1_i, decoded_rs2_i;
  logic      alu_ready_i, lsu_ready_i, mult_ready_i;
  logic      alu_valid_o, lsu_valid_o, mult_valid_o, stall_issue_o;
  op_t       fu_op_o;
  trans_id_t fu_trans_id_o;
  xlen_t     operand_a_o, operand_b_o;
  logic      wb_valid_i;
  trans_id_t wb_id_i;
  xlen_t     wb_data_i;
  logic      commit_valid_o, commit_ack_i, we_i;
  reg_addr_t commit_rd_o, waddr_i;
  xlen_t     commit_result_o, wdata_i;

  // Stimulus table
  vec_t  vecs [9];
  string vec_name [9];
  int    nv = 0;
  xlen_t result_by_op [16];

  // Model state
  int unsigned lcg_state = 16;
  int          cycle = 0;
  int          errors = 0;
  int          sent = 0;
  int          commits = 0;
  int          lsu_count = 0;
  logic        hold_commit = 1'b0;
  logic        hold_wb = 1'b0;
  logic        aborted = 1'b0;
  trans_id_t   pend_id [$];
  xlen_t       pend_data [$];
  int          pend_due [$];

  // Expected commits in program order
  string       exp_name_q [$];
  reg_addr_t   exp_rd_q [$];
  xlen_t       exp_res_q [$];

  issue_stage uut (.*);

  always #4 clk_i = ~clk_i;

  function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // ------------------------------
  // Functional unit model
  // ------------------------------
  always @(posedge clk_i) begin
    int d;
    cycle <= cycle + 1;
    if (flush_i) begin
      pend_id.delete();
      pend_data.delete();
      pend_due.delete();
      wb_valid_i <= 1'b0;
    end else begin
      // Capture a dispatch accepted at this edge
      if ((alu_valid_o && alu_ready_i) || (lsu_valid_o && lsu_ready_i) ||
          (mult_valid_o && mult_ready_i)) begin
        d = 1 + int'((lcg_next() >> 16) % 4);
        pend_id.push_back(fu_trans_id_o);
        pend_data.push_back(result_by_op[fu_op_o]);
        pend_due.push_back(cycle + d);
        if (lsu_valid_o) lsu_count <= lsu_count + 1;
      end
      if (pend_id.size() > 0 && !hold_wb && cycle >= pend_due[0]) begin
        wb_valid_i <= 1'b1;
        wb_id_i    <= pend_id.pop_front();
        wb_data_i  <= pend_data.pop_front();
        void'(pend_due.pop_front());
      end else begin
        wb_valid_i <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Commit model
  // ------------------------------
  // Ack every other cycle at most, the head moves only after the ack edge
  always @(posedge clk_i) begin
    if (commit_ack_i) commits <= commits + 1;
    if (commit_valid_o && !commit_ack_i && !hold_commit && !flush_i) begin
      // Head must be the oldest accepted instruction
      if (exp_rd_q.size() == 0) begin
        $display("Commit offered with no instruction in flight");
        errors++;
      end else begin
        check_value(exp_name_q[0], "commit_rd_o", 32'(exp_rd_q[0]), 32'(commit_rd_o));
        check_value(exp_name_q[0], "commit_result_o", 32'(exp_res_q[0]),
                    32'(commit_result_o));
        void'(exp_name_q.pop_front());
        void'(exp_rd_q.pop_front());
        void'(exp_res_q.pop_front());
      end
      commit_ack_i <= 1'b1;
      we_i         <= 1'b1;
      waddr_i      <= commit_rd_o;
      wdata_i      <= commit_result_o;
    end else begin
      commit_ack_i <= 1'b0;
      we_i         <= 1'b0;
    end
  end

  task automatic add_vec(input string name, input fu_t fu, input op_t op,
                         input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                         input xlen_t result, input xlen_t a, input xlen_t b,
                         input logic [2:0] mode);
    vec_name[nv] = name;
    vecs[nv] = '{fu, op, rd, rs1, rs2, result, a, b, mode};
    result_by_op[op] = result;
    nv++;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s expected %0h actual %0h", name, what, exp, act);
      errors++;
    end
  endtask

  // Stops the sequence, the closing report shows the failure
  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    aborted = 1'b1;
  endtask

  function automatic logic unit_valid(input fu_t fu);
    case (fu)
      FU_ALU:  return alu_valid_o;
      FU_LSU:  return lsu_valid_o;
      default: return mult_valid_o;
    endcase
  endfunction

  // Present one instruction until decode accepts it
  task automatic send(input int idx);
    int t;
    t = 0;
    if (aborted) return;
    @(posedge clk_i);
    decoded_valid_i <= 1'b1;
    decoded_fu_i    <= vecs[idx].fu;
    decoded_op_i    <= vecs[idx].op;
    decoded_rd_i    <= vecs[idx].rd;
    decoded_rs1_i   <= vecs[idx].rs1;
    decoded_rs2_i   <= vecs[idx].rs2;
    #1;
    while (!decoded_ack_o && t < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (!decoded_ack_o) begin
      timeout_fail("decode ack");
      return;
    end
    @(posedge clk_i);
    decoded_valid_i <= 1'b0;
    exp_name_q.push_back(vec_name[idx]);
    exp_rd_q.push_back(vecs[idx].rd);
    exp_res_q.push_back(vecs[idx].result);
    sent++;
  endtask

  // Wait for the unit valid, then check the dispatched payload
  task automatic wait_dispatch(input int idx, input logic check_id, input trans_id_t exp_id);
    int t;
    t = 0;
    if (aborted) return;
    @(posedge clk_i);
    #1;
    while (!unit_valid(vecs[idx].fu) && t < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (!unit_valid(vecs[idx].fu)) begin
      timeout_fail("unit valid");
      return;
    end
    check_value(vec_name[idx], "op", 32'(vecs[idx].op), 32'(fu_op_o));
    check_value(vec_name[idx], "operand_a", 32'(vecs[idx].exp_a), 32'(operand_a_o));
    check_value(vec_name[idx], "operand_b", 32'(vecs[idx].exp_b), 32'(operand_b_o));
    if (check_id) check_value(vec_name[idx], "trans_id", 32'(exp_id), 32'(fu_trans_id_o));
  endtask

  // Writebacks delivered, commits optional
  task automatic wait_wb_idle(input logic with_commits);
    int t;
    t = 0;
    if (aborted) return;
    while ((pend_id.size() != 0 || wb_valid_i || (with_commits && sent != commits))
           && t < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (pend_id.size() != 0 || wb_valid_i) timeout_fail("writebacks to drain");
    if (with_commits && sent != commits) timeout_fail("commits to drain");
  endtask

  // Fill the scoreboard, release one commit, refill, then flush
  task automatic fill_and_flush();
    int t;
    int c0;
    t = 0;
    hold_commit = 1'b1;
    repeat (4) send(0);
    if (aborted) return;
    #1;
    check_value("sb_full", "decoded_ack_o", 32'd0, 32'(decoded_ack_o));
    check_value("sb_full", "sb_full_o", 32'd1, 32'(sb_full_o));
    c0 = commits;
    hold_commit = 1'b0;
    while (sb_full_o && t < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (sb_full_o) begin
      timeout_fail("sb_full_o to drop");
      return;
    end
    check_value("sb_full", "commits", 32'd1, 32'(commits - c0));
    hold_commit = 1'b1;
    // Refill behind a stalled ALU so the flush has a held valid to drop
    @(posedge clk_i);
    alu_ready_i <= 1'b0;
    send(0);
    if (aborted) return;
    @(posedge clk_i);
    #1;
    check_value("flush", "held alu_valid_o", 32'd1, 32'(alu_valid_o));
    check_value("flush", "refilled sb_full_o", 32'd1, 32'(sb_full_o));
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i     <= 1'b0;
    alu_ready_i <= 1'b1;
    #1;
    check_value("flush", "unit valids", 32'd0,
                32'({alu_valid_o, lsu_valid_o, mult_valid_o}));
    check_value("flush", "commit_valid_o", 32'd0, 32'(commit_valid_o));
    check_value("flush", "sb_full_o", 32'd0, 32'(sb_full_o));
    // Flushed entries never commit
    exp_name_q.delete();
    exp_rd_q.delete();
    exp_res_q.delete();
    sent = commits;
    hold_commit = 1'b0;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int c0;
    int t;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_fu_i = FU_ALU;
    decoded_op_i = '0;
    decoded_rd_i = '0;
    decoded_rs1_i = '0;
    decoded_rs2_i = '0;
    alu_ready_i = 1'b1;
    lsu_ready_i = 1'b1;
    mult_ready_i = 1'b1;
    wb_valid_i = 1'b0;
    wb_id_i = '0;
    wb_data_i = '0;
    commit_ack_i = 1'b0;
    we_i = 1'b0;
    waddr_i = '0;
    wdata_i = '0;

    //       name          fu       op     rd    rs1   rs2   result    a         b
    add_vec("alu_r0",     FU_ALU,  4'd1, 3'd1, 3'd0, 3'd0, 16'h1111, 16'h0000, 16'h0000, M_PLAIN);
    add_vec("alu_r1",     FU_ALU,  4'd2, 3'd2, 3'd1, 3'd0, 16'h2222, 16'h1111, 16'h0000, M_PLAIN);
    add_vec("mul_r1r2",   FU_MULT, 4'd3, 3'd3, 3'd1, 3'd2, 16'h3333, 16'h1111, 16'h2222, M_PLAIN);
    add_vec("fwd_prod",   FU_ALU,  4'd4, 3'd5, 3'd1, 3'd0, 16'h5555, 16'h1111, 16'h0000, M_HOLD);
    add_vec("fwd_cons",   FU_MULT, 4'd5, 3'd6, 3'd5, 3'd2, 16'h6666, 16'h5555, 16'h2222, M_FWD);
    add_vec("raw_prod",   FU_ALU,  4'd6, 3'd7, 3'd2, 3'd3, 16'h7777, 16'h2222, 16'h3333, M_RAWP);
    add_vec("raw_cons",   FU_ALU,  4'd7, 3'd6, 3'd7, 3'd5, 16'h6a6a, 16'h7777, 16'h5555, M_RAW);
    add_vec("lsu_hold",   FU_LSU,  4'd8, 3'd2, 3'd7, 3'd1, 16'h2222, 16'h7777, 16'h1111, M_BP);
    add_vec("post_flush", FU_ALU,  4'd9, 3'd4, 3'd1, 3'd3, 16'h4444, 16'h1111, 16'h3333, M_FLUSH);

    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    #1;
    check_value("reset", "decoded_ack_o", 32'd1, 32'(decoded_ack_o));
    check_value("reset", "commit_valid_o", 32'd0, 32'(commit_valid_o));

    for (int i = 0; i < nv && !aborted; i++) begin
      case (vecs[i].mode)
        M_HOLD: begin
          // Result stays in the scoreboard for the next entry
          hold_commit = 1'b1;
          send(i);
          wait_dispatch(i, 1'b0, '0);
          wait_wb_idle(1'b0);
        end
        M_FWD: begin
          send(i);
          wait_dispatch(i, 1'b0, '0);
          hold_commit = 1'b0;
          wait_wb_idle(1'b1);
        end
        M_RAWP: begin
          hold_wb = 1'b1;
          send(i);
          wait_dispatch(i, 1'b0, '0);
        end
        M_RAW: begin
          send(i);
          t = 0;
          #1;
          while (!stall_issue_o && t < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            t++;
          end
          if (!stall_issue_o) timeout_fail("stall_issue_o");
          repeat (4) begin
            @(posedge clk_i);
            #1;
            check_value(vec_name[i], "alu_valid_o", 32'd0, 32'(alu_valid_o));
            check_value(vec_name[i], "stall_issue_o", 32'd1, 32'(stall_issue_o));
          end
          hold_wb = 1'b0;
          wait_dispatch(i, 1'b0, '0);
          wait_wb_idle(1'b1);
        end
        M_BP: begin
          @(posedge clk_i);
          lsu_ready_i <= 1'b0;
          c0 = lsu_count;
          send(i);
          // Ring slot of this entry, counted from reset
          wait_dispatch(i, 1'b1, trans_id_t'(sent - 1));
          repeat (3) begin
            @(posedge clk_i);
            #1;
            check_value(vec_name[i], "lsu_valid_o", 32'd1, 32'(lsu_valid_o));
            check_value(vec_name[i], "held operand_a", 32'(vecs[i].exp_a), 32'(operand_a_o));
            check_value(vec_name[i], "held operand_b", 32'(vecs[i].exp_b), 32'(operand_b_o));
            check_value(vec_name[i], "held trans_id", 32'(trans_id_t'(sent - 1)),
                        32'(fu_trans_id_o));
          end
          @(posedge clk_i);
          lsu_ready_i <= 1'b1;
          wait_wb_idle(1'b1);
          check_value(vec_name[i], "lsu dispatches", 32'd1, 32'(lsu_count - c0));
        end
        M_FLUSH: begin
          fill_and_flush();
          send(i);
          wait_dispatch(i, 1'b1, '0);
          wait_wb_idle(1'b1);
        end
        default: begin
          send(i);
          wait_dispatch(i, 1'b0, '0);
          wait_wb_idle(1'b1);
        end
      endcase
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/scoreboard.sv
hdl/issue_read_operands.sv
hdl/register_file.sv
hdl/issue_stage.sv
tests/tb_issue_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_issue_stage -f filelist.f -o sim_issue_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_issue_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
